// File: byte_mem.sv
`timescale 1ns/10ps

module byte_mem
        import mem_pkg::*;
#(
        parameter int MEM_AW = 12
)
(
        input  logic                    i_clk,

        input  mem_wr_t                 i_wr,

        input  logic [MEM_AW-3:0]       i_d_idx,       // Data side word index.
        output logic [WORD_W-1:0]       o_d_word,

        input  logic [MEM_AW-3:0]       i_i_idx,       // Instruction side.
        output logic [WORD_W-1:0]       o_i_word
);

localparam int IW    = MEM_AW - 2;
localparam int DEPTH = 2 ** IW;

logic [IW-1:0]  wr_idx;

assign wr_idx = i_wr.idx[IW-1:0];

// Little-endian: lane 0 holds the byte at the lowest address.
for (genvar l = 0; l < SEL_W; l++)
begin : g_lane
        logic [BYTE_W-1:0] lane_mem [DEPTH];

        always_ff @(posedge i_clk)
        begin
                if (i_wr.wr && i_wr.sel[l])
                begin
                        lane_mem[wr_idx] <= i_wr.dat[l*BYTE_W +: BYTE_W];
                end
        end

        // Reads are combinational. The callers register them.
        assign o_d_word[l*BYTE_W +: BYTE_W] = lane_mem[i_d_idx];
        assign o_i_word[l*BYTE_W +: BYTE_W] = lane_mem[i_i_idx];
end

endmodule

// File: dport_wb_slave.sv
`timescale 1ns/10ps

module dport_wb_slave
        import mem_pkg::*;
#(
        parameter int MEM_AW = 12
)
(
        input  logic                    i_clk,
        input  logic                    i_rst_n,

        input  logic                    i_wb_cyc,
        input  logic                    i_wb_stb,
        input  wb_req_t                 i_wb_req,

        input  logic                    i_d_miss,      // Stall this cycle.
        input  logic [WORD_W-1:0]       i_rd_word,

        output mem_wr_t                 o_wr,
        output logic [MEM_AW-3:0]       o_rd_idx,
        output wb_rsp_t                 o_wb_rsp
);

typedef enum logic {
        ST_IDLE,
        ST_BUSY
} state_t;

state_t                 state;
wb_req_t                req_q;
logic                   bad_q;
logic [WORD_W-1:0]      rdat_q;
logic                   strobe;
logic                   sample;
logic                   done;

assign strobe = i_wb_cyc && i_wb_stb;
assign sample = (state == ST_IDLE) && strobe;

// Busy, bus still asserted and no miss this cycle.
assign done = (state == ST_BUSY) && strobe && !i_d_miss;

always_ff @(posedge i_clk or negedge i_rst_n)
begin
        if (!i_rst_n)
        begin
                state <= ST_IDLE;
        end
        else
        begin
                case (state)
                ST_IDLE:
                        if (sample)
                                state <= ST_BUSY;
                ST_BUSY:
                        if (done || !strobe)
                                state <= ST_IDLE;   // Done, or master gave up.
                default:
                        state <= ST_IDLE;
                endcase
        end
end

// The read index follows the live address, so the word is ready at the sample edge.
assign o_rd_idx = i_wb_req.adr[MEM_AW-1:2];

always_ff @(posedge i_clk)
begin
        if (sample)
        begin
                req_q  <= i_wb_req;
                bad_q  <= addr_abort(i_wb_req.adr, MEM_AW);
                rdat_q <= i_rd_word;
        end
end

always_comb
begin
        o_wr.idx = req_q.adr[WORD_W-1:2];
        o_wr.sel = req_q.sel;
        o_wr.dat = req_q.dat;
        o_wr.wr  = done && req_q.we && !bad_q;   // Lands at the end of the ack cycle.

        o_wb_rsp.dat = rdat_q;
        o_wb_rsp.ack = done && !bad_q;
        o_wb_rsp.err = done && bad_q;
end

endmodule

// File: dual_mem_chk.sv
`timescale 1ns/10ps

module dual_mem_chk
        import mem_pkg::*;
(
        input  logic            i_clk,
        input  logic            i_rst_n,
        input  logic            i_wb_stb,
        input  wb_rsp_t         i_wb_rsp,
        input  logic            i_if_req,
        input  if_rsp_t         i_if_rsp
);

// One kind of answer per request.
a_ack_err_excl: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !(i_wb_rsp.ack && i_wb_rsp.err))
        else $error("Data port ack and err are high together");

a_rsp_needs_stb: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !i_wb_stb |-> !(i_wb_rsp.ack || i_wb_rsp.err))
        else $error("Data port answered while stb was low");

// The CPU holds its request through the hit cycle.
a_hit_needs_req: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_if_rsp.hit |-> i_if_req)
        else $error("Instruction hit without a request");

endmodule

bind dual_mem_top dual_mem_chk dual_mem_chk_inst (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_wb_stb       (i_wb_stb),
        .i_wb_rsp       (o_wb_rsp),
        .i_if_req       (i_if_req),
        .i_if_rsp       (o_if_rsp)
);

// File: dual_mem_golden.txt
# port(D data, I fetch) op(R/W) addr sel wdata expected outcome(ack err hit abt)
# all numbers hex, expected data checked on data reads that ack and on fetches that hit
D W 00000000 f 11223344 00000000 ack
D R 00000000 f 00000000 11223344 ack
D W 00000004 f deadbeef 00000000 ack
D R 00000004 f 00000000 deadbeef ack
D W 00000ffc f cafef00d 00000000 ack
D R 00000ffc f 00000000 cafef00d ack
D W 00000010 f a5a5a5a5 00000000 ack
D W 00000010 1 000000ff 00000000 ack
D R 00000010 f 00000000 a5a5a5ff ack
D W 00000010 4 00ee0000 00000000 ack
D W 00000010 8 7e000000 00000000 ack
D R 00000010 f 00000000 7eeea5ff ack
D W 00000010 2 00003c00 00000000 ack
D R 00000010 f 00000000 7eee3cff ack
D W 00000020 f 00000000 00000000 ack
D W 00000020 3 12345678 00000000 ack
D R 00000020 f 00000000 00005678 ack
D W 00000020 c 9abcdef0 00000000 ack
D W 00000020 5 ffffffff 00000000 ack
D R 00000020 f 00000000 9aff56ff ack
I R 00000000 0 00000000 11223344 hit
I R 00000004 0 00000000 deadbeef hit
I R 00000010 0 00000000 7eee3cff hit
I R 00000020 0 00000000 9aff56ff hit
I R 00000ffc 0 00000000 cafef00d hit
D W 00000012 f 0badf00d 00000000 err
D W 00001010 f 0badf00d 00000000 err
D R 00000010 f 00000000 7eee3cff ack
D W 00000001 f 0badf00d 00000000 err
D W 00001000 f 0badf00d 00000000 err
D R 00000000 f 00000000 11223344 ack
D R 00000003 f 00000000 00000000 err
D R 80000000 f 00000000 00000000 err
I R 00000002 0 00000000 00000000 abt
I R 00001000 0 00000000 00000000 abt
I R fffffffc 0 00000000 00000000 abt
D W 00000100 f 01020304 00000000 ack
I R 00000100 0 00000000 01020304 hit
D W 00000104 f 05060708 00000000 ack
I R 00000104 0 00000000 05060708 hit
D W 00000100 2 0000aa00 00000000 ack
I R 00000100 0 00000000 0102aa04 hit
D R 00000104 f 00000000 05060708 ack
I R 00000006 0 00000000 00000000 abt
D R 00000100 f 00000000 0102aa04 ack
D W 00000200 f 76543210 00000000 ack
I R 00000200 0 00000000 76543210 hit
D R 00000202 f 00000000 00000000 err
I R 00000000 0 00000000 11223344 hit
D R 00000200 f 00000000 76543210 ack

// File: dual_mem_tb.sv
`timescale 1ns/10ps

module dual_mem_tb
        import mem_pkg::*;
();

localparam int MEM_AW     = 12;
localparam int RST_CYCLES = 10;
localparam int MAX_LINES  = 256;

logic                   i_clk;
logic                   i_rst_n;
logic                   wb_cyc;
logic                   wb_stb;
wb_req_t                wb_req;
wb_rsp_t                wb_rsp;
logic                   if_req;
logic [WORD_W-1:0]      if_addr;
if_rsp_t                if_rsp;

integer                 seed = 36949;
int                     errors = 0;
int                     checks = 0;
int                     n_lines = 0;
int                     gap;
logic                   loaded = 1'b0;

// One golden access per entry.
logic [7:0]             g_port [MAX_LINES];
logic [7:0]             g_op   [MAX_LINES];
logic [WORD_W-1:0]      g_addr [MAX_LINES];
logic [SEL_W-1:0]       g_sel  [MAX_LINES];
logic [WORD_W-1:0]      g_wdat [MAX_LINES];
logic [WORD_W-1:0]      g_exp  [MAX_LINES];
logic [23:0]            g_res  [MAX_LINES];     // ack, err, hit or abt.

initial i_clk = 1'b0;
always #2 i_clk = ~i_clk;

dual_mem_top #(
        .MEM_AW         (MEM_AW)
) dual_mem_top_inst (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_wb_cyc       (wb_cyc),
        .i_wb_stb       (wb_stb),
        .i_wb_req       (wb_req),
        .o_wb_rsp       (wb_rsp),
        .i_if_req       (if_req),
        .i_if_addr      (if_addr),
        .o_if_rsp       (if_rsp)
);

task automatic check_wb_rsp(input wb_rsp_t act, input wb_rsp_t exp, input bit cmp_dat,
                            input int k);
        logic ok;
        checks++;
        ok = (act.ack === exp.ack) && (act.err === exp.err);
        if (cmp_dat)
                ok = ok && (act.dat === exp.dat);
        if (!ok)
        begin
                errors++;
                $display("CHECK FAILED at %0t: access %0d data port ack=%b err=%b dat=%h, %s",
                         $time, k, act.ack, act.err, act.dat, "expected below");
                $display("        expected ack=%b err=%b dat=%h", exp.ack, exp.err, exp.dat);
        end
endtask

task automatic check_if_rsp(input if_rsp_t act, input if_rsp_t exp, input bit cmp_word,
                            input int k);
        logic ok;
        checks++;
        ok = (act.hit === exp.hit) && (act.abort === exp.abort);
        if (cmp_word)
                ok = ok && (act.word === exp.word);
        if (!ok)
        begin
                errors++;
                $display("CHECK FAILED at %0t: access %0d fetch abort=%b word=%h, expected %b %h",
                         $time, k, act.abort, act.word, exp.abort, exp.word);
        end
endtask

task automatic load_golden();
        int fd;
        int n;
        string text;
        fd = $fopen("dual_mem_golden.txt", "r");
        if (fd == 0)
        begin
                errors++;
                $display("Could not open the golden file dual_mem_golden.txt");
                return;
        end
        while ($fgets(text, fd) != 0 && n_lines < MAX_LINES)
        begin
                if (text.len() < 2 || text[0] == "#")
                        continue;       // Column notes and blank lines.
                n = $sscanf(text, "%s %s %h %h %h %h %s", g_port[n_lines], g_op[n_lines],
                            g_addr[n_lines], g_sel[n_lines], g_wdat[n_lines],
                            g_exp[n_lines], g_res[n_lines]);
                if (n == 7)
                        n_lines++;
                else
                begin
                        errors++;
                        $display("Golden file line could not be parsed: %s", text);
                end
        end
        $fclose(fd);
endtask

// Called on a falling edge. Holds the request until ack or err.
task automatic run_data(input int k);
        wb_rsp_t exp;
        wb_rsp_t got;
        int waits;
        wb_req.adr = g_addr[k];
        wb_req.we  = (g_op[k] == "W");
        wb_req.sel = g_sel[k];
        wb_req.dat = g_wdat[k];
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        waits = 0;
        #1 got = wb_rsp;
        while (!(got.ack || got.err))
        begin
                @(negedge i_clk);
                waits++;
                #1 got = wb_rsp;
        end
        if (waits == 0)
        begin
                errors++;
                $display("Data port answered in the cycle of the request, access %0d", k);
        end
        exp.dat = g_exp[k];
        exp.ack = (g_res[k] == "ack");
        exp.err = (g_res[k] == "err");
        check_wb_rsp(got, exp, !wb_req.we && exp.ack, k);
        @(negedge i_clk);
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
endtask

task automatic run_fetch(input int k);
        if_rsp_t exp;
        if_rsp_t got;
        if_req  = 1'b1;
        if_addr = g_addr[k];
        #1 got = if_rsp;
        while (!got.hit)
        begin
                @(negedge i_clk);
                #1 got = if_rsp;
        end
        exp.word  = g_exp[k];
        exp.hit   = 1'b1;
        exp.abort = (g_res[k] == "abt");
        check_if_rsp(got, exp, !exp.abort, k);
        @(negedge i_clk);
        if_req = 1'b0;
endtask

initial
begin
        i_rst_n = 1'b0;
        wb_cyc  = 1'b0;
        wb_stb  = 1'b0;
        wb_req  = '0;
        if_req  = 1'b0;
        if_addr = '0;
        load_golden();
        loaded = 1'b1;
        if (n_lines == 0)
        begin
                errors++;
                $display("The golden file holds no accesses");
        end
        repeat (RST_CYCLES) @(negedge i_clk);
        i_rst_n = 1'b1;
        for (int k = 0; k < n_lines; k++)
        begin
                gap = $unsigned($random(seed)) % 4;     // Random idle cycles.
                repeat (gap) @(negedge i_clk);
                @(negedge i_clk);
                if (g_port[k] == "D")
                        run_data(k);
                else if (g_port[k] == "I")
                        run_fetch(k);
                else
                begin
                        errors++;
                        $display("Unknown port in golden access %0d", k);
                end
        end
        repeat (4) @(negedge i_clk);
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
                $display("Verification passed");
        else
                $display("Verification failed");
        $finish;
end

// Generous bound per access, covers long miss runs.
initial
begin
        wait (loaded);
        repeat (RST_CYCLES + 16 + n_lines * 64) @(posedge i_clk);
        $display("Timeout, the accesses did not complete in time");
        $display("Checks: %0d, errors: %0d", checks, errors);
        $display("Verification failed");
        $finish;
end

endmodule

// File: dual_mem_top.f
mem_pkg.sv
dport_wb_slave.sv
miss_lfsr.sv
byte_mem.sv
ifetch_port.sv
dual_mem_top.sv
dual_mem_chk.sv
dual_mem_tb.sv

// File: dual_mem_top.sv
`timescale 1ns/10ps

module dual_mem_top
        import mem_pkg::*;
#(
        parameter int                   MEM_AW    = 12,
        parameter logic [LFSR_W-1:0]    LFSR_SEED = 16'hACE1
)
(
        input  logic                    i_clk,
        input  logic                    i_rst_n,

        input  logic                    i_wb_cyc,
        input  logic                    i_wb_stb,
        input  wb_req_t                 i_wb_req,
        output wb_rsp_t                 o_wb_rsp,

        input  logic                    i_if_req,
        input  logic [WORD_W-1:0]       i_if_addr,
        output if_rsp_t                 o_if_rsp
);

mem_wr_t                d_wr;
logic [MEM_AW-3:0]      d_idx;
logic [MEM_AW-3:0]      i_idx;
logic [WORD_W-1:0]      d_word;
logic [WORD_W-1:0]      i_word;
logic                   d_miss;
logic                   i_miss;

dport_wb_slave #(
        .MEM_AW         (MEM_AW)
) dport_wb_slave_inst (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_wb_cyc       (i_wb_cyc),
        .i_wb_stb       (i_wb_stb),
        .i_wb_req       (i_wb_req),
        .i_d_miss       (d_miss),
        .i_rd_word      (d_word),
        .o_wr           (d_wr),
        .o_rd_idx       (d_idx),
        .o_wb_rsp       (o_wb_rsp)
);

miss_lfsr #(
        .LFSR_SEED      (LFSR_SEED)
) miss_lfsr_inst (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .o_d_miss       (d_miss),
        .o_i_miss       (i_miss)
);

byte_mem #(
        .MEM_AW         (MEM_AW)
) byte_mem_inst (
        .i_clk          (i_clk),
        .i_wr           (d_wr),
        .i_d_idx        (d_idx),
        .o_d_word       (d_word),
        .i_i_idx        (i_idx),
        .o_i_word       (i_word)
);

ifetch_port #(
        .MEM_AW         (MEM_AW)
) ifetch_port_inst (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_if_req       (i_if_req),
        .i_if_addr      (i_if_addr),
        .i_i_miss       (i_miss),
        .i_word         (i_word),
        .o_idx          (i_idx),
        .o_if_rsp       (o_if_rsp)
);

endmodule

// File: ifetch_port.sv
`timescale 1ns/10ps

module ifetch_port
        import mem_pkg::*;
#(
        parameter int MEM_AW = 12
)
(
        input  logic                    i_clk,
        input  logic                    i_rst_n,

        input  logic                    i_if_req,
        input  logic [WORD_W-1:0]       i_if_addr,

        input  logic                    i_i_miss,
        input  logic [WORD_W-1:0]       i_word,

        output logic [MEM_AW-3:0]       o_idx,
        output if_rsp_t                 o_if_rsp
);

logic                   pend;           // Fetch accepted, not yet answered.
logic                   hit_q;
logic                   abort_q;
logic [WORD_W-1:0]      addr_q;
logic [WORD_W-1:0]      word_q;
logic                   start;
logic                   answer;

// Not during the hit cycle, the CPU still holds the old address then.
assign start  = i_if_req && !pend && !hit_q;
assign answer = pend && !i_i_miss;

always_ff @(posedge i_clk or negedge i_rst_n)
begin
        if (!i_rst_n)
        begin
                pend    <= 1'b0;
                hit_q   <= 1'b0;
                abort_q <= 1'b0;
        end
        else
        begin
                if (start)
                        pend <= 1'b1;
                else if (answer)
                        pend <= 1'b0;

                hit_q   <= answer;      // One cycle pulse.
                abort_q <= answer && addr_abort(addr_q, MEM_AW);
        end
end

always_ff @(posedge i_clk)
begin
        if (start)
                addr_q <= i_if_addr;
        if (answer)
                word_q <= i_word;
end

assign o_idx = addr_q[MEM_AW-1:2];

always_comb
begin
        o_if_rsp.word  = word_q;
        o_if_rsp.hit   = hit_q;
        o_if_rsp.abort = abort_q;
end

endmodule

// File: mem_pkg.sv
package mem_pkg;

        localparam int WORD_W = 32;             // Data bus width.
        localparam int SEL_W  = 4;              // One select per byte lane.
        localparam int BYTE_W = 8;
        localparam int IDX_W  = WORD_W - 2;     // Word index of a byte address.

        // Low address bits that must be clear for a word access.
        localparam logic [1:0] ALIGN_MASK = 2'b11;

        // Miss generator width and Galois feedback mask.
        localparam int LFSR_W = 16;
        localparam logic [LFSR_W-1:0] LFSR_POLY = 16'hB400;

        typedef struct packed {
                logic [WORD_W-1:0]      adr;
                logic                   we;
                logic [SEL_W-1:0]       sel;
                logic [WORD_W-1:0]      dat;
        } wb_req_t;

        typedef struct packed {
                logic [WORD_W-1:0]      dat;
                logic                   ack;
                logic                   err;
        } wb_rsp_t;

        typedef struct packed {
                logic [IDX_W-1:0]       idx;
                logic [SEL_W-1:0]       sel;
                logic [WORD_W-1:0]      dat;
                logic                   wr;
        } mem_wr_t;

        typedef struct packed {
                logic [WORD_W-1:0]      word;
                logic                   hit;
                logic                   abort;
        } if_rsp_t;

        // Misaligned, or beyond the aw-bit memory.
        function automatic logic addr_abort(input logic [WORD_W-1:0] addr,
                                            input int unsigned aw);
                return ((addr[1:0] & ALIGN_MASK) != 2'b00) || ((addr >> aw) != '0);
        endfunction

endpackage

// File: miss_lfsr.sv
`timescale 1ns/10ps

module miss_lfsr
        import mem_pkg::*;
#(
        parameter logic [LFSR_W-1:0] LFSR_SEED = 16'hACE1
)
(
        input  logic    i_clk,
        input  logic    i_rst_n,

        output logic    o_d_miss,
        output logic    o_i_miss
);

// An all-zero state would lock up.
localparam logic [LFSR_W-1:0] SEED = (LFSR_SEED == '0) ? 16'h0001 : LFSR_SEED;

logic [LFSR_W-1:0]      lfsr;
logic [LFSR_W-1:0]      lfsr_next;

always_comb
begin
        lfsr_next = {1'b0, lfsr[LFSR_W-1:1]};
        if (lfsr[0])
        begin
                lfsr_next = lfsr_next ^ LFSR_POLY;
        end
end

always_ff @(posedge i_clk or negedge i_rst_n)
begin
        if (!i_rst_n)
        begin
                lfsr <= SEED;
        end
        else
        begin
                lfsr <= lfsr_next;      // Free running.
        end
end

// Two taps ANDed, so about one cycle in four misses.
// Separate tap pairs keep the two sides loosely correlated.
assign o_d_miss = lfsr[3] & lfsr[9];
assign o_i_miss = lfsr[6] & lfsr[12];

endmodule
